// ==== logic/ddr_test_pkg.sv ====
package ddr_test_pkg;

  localparam int BURST_ADDR_STEP = 8;  // app address units per burst
  localparam int LANES           = 4;  // memory devices sharing the data bus

  typedef logic [28:0] app_addr_t;
  typedef logic [15:0] pat_word_t;     // replicated over the whole bus
  typedef logic [31:0] run_cnt_t;      // cycle and run counters

  typedef enum logic [2:0] {
    cmd_wr = 3'd0,
    cmd_rd = 3'd1
  } cmd_e;

  typedef enum logic [1:0] {
    full_incr  = 2'd0,
    full_fixed = 2'd1,
    part_incr  = 2'd2,
    part_fixed = 2'd3
  } test_mode_e;

  typedef enum logic [1:0] {
    not_started = 2'd0,
    testing     = 2'd1,
    passed      = 2'd2,
    failed      = 2'd3
  } test_status_e;

  typedef enum logic [2:0] {
    st_idle, st_start, st_write, st_write_end, st_read, st_read_end, st_finish
  } test_state_e;

  typedef struct packed {
    test_mode_e mode;
    pat_word_t  fixed_data;
    app_addr_t  start_addr;  // burst aligned
    app_addr_t  end_addr;
  } test_cfg_t;

  typedef struct packed {
    app_addr_t base_addr;    // zero in full modes
    app_addr_t end_addr;
    logic      incr;         // incrementing pattern
    pat_word_t fixed_word;
  } run_cfg_t;

endpackage

// ==== logic/ddr_test_seq.sv ====
module ddr_test_seq #(
  parameter int PASSES_FULL = 3
) (
  input  logic                       W_uclk,
  input  logic                       W_urst,
  input  logic                       test_en,
  input  ddr_test_pkg::test_cfg_t    test_cfg,
  input  logic                       init_done,
  input  logic                       wr_done,
  input  logic                       rd_done,
  input  ddr_test_pkg::app_addr_t    rd_addr,
  input  logic                       fail,
  output ddr_test_pkg::test_state_e  state,
  output ddr_test_pkg::run_cfg_t     run,
  output ddr_test_pkg::test_status_e test_status,
  output ddr_test_pkg::run_cnt_t     test_time,
  output ddr_test_pkg::run_cnt_t     test_finish_cnt
);

  localparam int PASS_W = $clog2(PASSES_FULL + 1);

  ddr_test_pkg::test_state_e state_nxt;
  logic                      test_en_d;
  logic                      full_cfg;
  logic                      full_range;  // latched with run
  logic [PASS_W-1:0]         pass_cnt;
  logic                      go;
  logic                      range_done;

  assign full_cfg = (test_cfg.mode == ddr_test_pkg::full_incr) ||
                    (test_cfg.mode == ddr_test_pkg::full_fixed);

  // a failed run only restarts on a fresh enable edge
  assign go = init_done && (fail ? (test_en && !test_en_d) : test_en);

  assign range_done = full_range ? (pass_cnt >= PASS_W'(PASSES_FULL))
                                 : (rd_addr >= run.end_addr);

  always_comb
  begin
    state_nxt = state;
    case (state)
      ddr_test_pkg::st_idle:
        if (go)
          state_nxt = ddr_test_pkg::st_start;
      ddr_test_pkg::st_start:
        state_nxt = ddr_test_pkg::st_write;
      ddr_test_pkg::st_write:
        if (wr_done)
          state_nxt = ddr_test_pkg::st_write_end;
      ddr_test_pkg::st_write_end:
        state_nxt = ddr_test_pkg::st_read;
      ddr_test_pkg::st_read:
        if (fail)
          state_nxt = ddr_test_pkg::st_finish;  // abandon the pass
        else if (rd_done)
          state_nxt = ddr_test_pkg::st_read_end;
      ddr_test_pkg::st_read_end:
        state_nxt = range_done ? ddr_test_pkg::st_finish : ddr_test_pkg::st_write;
      default:
        state_nxt = ddr_test_pkg::st_idle;
    endcase
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
    begin
      state     <= ddr_test_pkg::st_idle;
      test_en_d <= 1'b0;
    end
    else
    begin
      state     <= state_nxt;
      test_en_d <= test_en;
    end
  end

  // configuration only follows the inputs while idle
  always_ff @(posedge W_uclk)
  begin
    if (state == ddr_test_pkg::st_idle)
    begin
      full_range     <= full_cfg;
      run.base_addr  <= full_cfg ? '0 : test_cfg.start_addr;
      run.end_addr   <= test_cfg.end_addr;
      run.incr       <= (test_cfg.mode == ddr_test_pkg::full_incr) ||
                        (test_cfg.mode == ddr_test_pkg::part_incr);
      run.fixed_word <= test_cfg.fixed_data;
    end
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      pass_cnt <= '0;
    else if (state == ddr_test_pkg::st_start)
      pass_cnt <= '0;
    else if (state == ddr_test_pkg::st_write_end)
      pass_cnt <= pass_cnt + 1'b1;  // one per write pass
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      test_status <= ddr_test_pkg::not_started;
    else if (state == ddr_test_pkg::st_start)
      test_status <= ddr_test_pkg::testing;
    else if (state == ddr_test_pkg::st_finish)
      test_status <= fail ? ddr_test_pkg::failed : ddr_test_pkg::passed;
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      test_time <= '0;
    else if (state == ddr_test_pkg::st_start)
      test_time <= '0;
    else if (test_status == ddr_test_pkg::testing)
      test_time <= test_time + 1'b1;  // cycles of the current run
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      test_finish_cnt <= '0;
    else if (!test_en)
      test_finish_cnt <= '0;
    else if (state == ddr_test_pkg::st_finish)
      test_finish_cnt <= test_finish_cnt + 1'b1;
  end

endmodule

// ==== logic/ddr_app_issue.sv ====
module ddr_app_issue #(
  parameter int APP_DATA_W      = 128,
  parameter int BURSTS_PER_PASS = 8
) (
  input  logic                      W_uclk,
  input  logic                      W_urst,
  input  ddr_test_pkg::test_state_e state,
  input  ddr_test_pkg::run_cfg_t    run,
  input  logic                      app_rdy,
  input  logic                      app_wdf_rdy,
  output logic                      app_en,
  output ddr_test_pkg::cmd_e        app_cmd,
  output ddr_test_pkg::app_addr_t   app_addr,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  output logic [APP_DATA_W-1:0]     app_wdf_data,
  output logic                      wr_done,
  output ddr_test_pkg::app_addr_t   rd_addr
);

  localparam int CNT_W = $clog2(BURSTS_PER_PASS + 1);
  localparam int REPS  = APP_DATA_W / 16;

  logic                    is_wr;
  logic                    in_pass;
  logic                    acc;       // command taken by the controller
  logic                    last_acc;
  logic                    cnt_clr;
  logic [CNT_W-1:0]        cmd_cnt;
  ddr_test_pkg::app_addr_t wr_addr;
  ddr_test_pkg::pat_word_t wr_word;
  ddr_test_pkg::pat_word_t data_word;

  assign is_wr    = (app_cmd == ddr_test_pkg::cmd_wr);
  assign in_pass  = (state == ddr_test_pkg::st_write) || (state == ddr_test_pkg::st_read);
  assign acc      = app_en && app_rdy && (!is_wr || app_wdf_rdy);
  assign last_acc = acc && (cmd_cnt == CNT_W'(BURSTS_PER_PASS - 1));
  assign cnt_clr  = (state == ddr_test_pkg::st_start) ||
                    (state == ddr_test_pkg::st_write_end) ||
                    (state == ddr_test_pkg::st_read_end);

  assign app_wdf_wren = acc && is_wr;
  assign app_wdf_end  = app_wdf_wren;  // single beat bursts
  assign app_addr     = is_wr ? wr_addr : rd_addr;
  assign data_word    = run.incr ? wr_word : run.fixed_word;
  assign app_wdf_data = {REPS{data_word}};

  // request stays up until the last burst of the pass is taken
  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
    begin
      app_en  <= 1'b0;
      app_cmd <= ddr_test_pkg::cmd_wr;
    end
    else
    begin
      app_en <= in_pass && !last_acc && (cmd_cnt < CNT_W'(BURSTS_PER_PASS));
      if (state == ddr_test_pkg::st_write)
        app_cmd <= ddr_test_pkg::cmd_wr;
      else if (state == ddr_test_pkg::st_read)
        app_cmd <= ddr_test_pkg::cmd_rd;
    end
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      cmd_cnt <= '0;
    else if (cnt_clr)
      cmd_cnt <= '0;
    else if (acc)
      cmd_cnt <= cmd_cnt + 1'b1;
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
    begin
      wr_addr <= '0;
      rd_addr <= '0;
      wr_word <= '0;
      wr_done <= 1'b0;
    end
    else if (state == ddr_test_pkg::st_start)
    begin
      wr_addr <= run.base_addr;
      rd_addr <= run.base_addr;
      wr_word <= '0;
      wr_done <= 1'b0;
    end
    else
    begin
      if (app_wdf_wren)
      begin
        wr_addr <= wr_addr + ddr_test_pkg::app_addr_t'(ddr_test_pkg::BURST_ADDR_STEP);
        wr_word <= wr_word + 1'b1;  // word k for burst k
      end
      if (acc && !is_wr)
        rd_addr <= rd_addr + ddr_test_pkg::app_addr_t'(ddr_test_pkg::BURST_ADDR_STEP);
      if (state == ddr_test_pkg::st_write_end)
        wr_done <= 1'b0;
      else if (app_wdf_wren && last_acc)
        wr_done <= 1'b1;
    end
  end

endmodule

// ==== logic/ddr_rd_check.sv ====
module ddr_rd_check #(
  parameter int APP_DATA_W      = 128,
  parameter int BURSTS_PER_PASS = 8
) (
  input  logic                             W_uclk,
  input  logic                             W_urst,
  input  ddr_test_pkg::test_state_e        state,
  input  ddr_test_pkg::run_cfg_t           run,
  input  logic                             app_rd_vld,
  input  logic [APP_DATA_W-1:0]            app_rd_data,
  output logic                             fail,
  output logic                             rd_done,
  output ddr_test_pkg::app_addr_t          fail_addr,
  output logic [APP_DATA_W-1:0]            fail_right_data,
  output logic [APP_DATA_W-1:0]            fail_fact_data,
  output logic [ddr_test_pkg::LANES-1:0]   err_lane_mask
);

  localparam int CNT_W  = $clog2(BURSTS_PER_PASS + 1);
  localparam int REPS   = APP_DATA_W / 16;
  localparam int LANE_W = APP_DATA_W / ddr_test_pkg::LANES;

  logic                    clr;        // start of a run
  logic                    pass_clr;
  logic                    last_beat;
  logic                    mismatch;
  logic [CNT_W-1:0]        beat_cnt;
  logic [2:0]              done_pipe;  // lets the fail registers settle
  ddr_test_pkg::pat_word_t exp_word;
  ddr_test_pkg::app_addr_t vld_addr;
  logic [APP_DATA_W-1:0]   exp_data;

  assign clr       = (state == ddr_test_pkg::st_start);
  assign pass_clr  = clr || (state == ddr_test_pkg::st_read_end);
  assign exp_data  = {REPS{run.incr ? exp_word : run.fixed_word}};
  assign mismatch  = app_rd_vld && (app_rd_data != exp_data);
  assign last_beat = app_rd_vld && (state == ddr_test_pkg::st_read) &&
                     (beat_cnt == CNT_W'(BURSTS_PER_PASS - 1));
  assign rd_done   = done_pipe[2];

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
    begin
      beat_cnt  <= '0;
      done_pipe <= '0;
    end
    else if (pass_clr)
    begin
      beat_cnt  <= '0;
      done_pipe <= '0;
    end
    else
    begin
      if (app_rd_vld)
        beat_cnt <= beat_cnt + 1'b1;
      done_pipe <= {done_pipe[1:0], done_pipe[0] | last_beat};
    end
  end

  // expected word and address follow the returned beats in order
  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
    begin
      exp_word <= '0;
      vld_addr <= '0;
    end
    else if (clr)
    begin
      exp_word <= '0;
      vld_addr <= run.base_addr;
    end
    else if (app_rd_vld)
    begin
      exp_word <= exp_word + 1'b1;
      vld_addr <= vld_addr + ddr_test_pkg::app_addr_t'(ddr_test_pkg::BURST_ADDR_STEP);
    end
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      fail <= 1'b0;
    else if (clr)
      fail <= 1'b0;
    else if (mismatch)
      fail <= 1'b1;  // sticky until the next run
  end

  always_ff @(posedge W_uclk)
  begin
    if (clr)
    begin
      fail_addr       <= '0;
      fail_right_data <= '0;
      fail_fact_data  <= '0;
    end
    else if (mismatch && !fail)
    begin
      fail_addr       <= vld_addr;  // first failure only
      fail_right_data <= exp_data;
      fail_fact_data  <= app_rd_data;
    end
  end

  always_ff @(posedge W_uclk)
  begin
    if (W_urst)
      err_lane_mask <= '0;
    else if (clr)
      err_lane_mask <= '0;
    else if (fail)
      for (int i = 0; i < ddr_test_pkg::LANES; i++)
        err_lane_mask[i] <= (fail_right_data[i*LANE_W +: LANE_W] !=
                             fail_fact_data[i*LANE_W +: LANE_W]);
  end

endmodule

// ==== logic/ddr_selftest.sv ====
module ddr_selftest #(
  parameter int APP_DATA_W      = 128,  // multiple of 16 and of the lane count
  parameter int BURSTS_PER_PASS = 8,
  parameter int PASSES_FULL     = 3
) (
  input  logic                             W_uclk,
  input  logic                             W_urst,
  input  logic                             test_en,
  input  ddr_test_pkg::test_cfg_t          test_cfg,
  input  logic                             init_done,
  output logic                             app_en,
  output ddr_test_pkg::cmd_e               app_cmd,
  output ddr_test_pkg::app_addr_t          app_addr,
  output logic                             app_wdf_wren,
  output logic                             app_wdf_end,
  output logic [APP_DATA_W-1:0]            app_wdf_data,
  input  logic                             app_rdy,
  input  logic                             app_wdf_rdy,
  input  logic                             app_rd_vld,
  input  logic [APP_DATA_W-1:0]            app_rd_data,
  output ddr_test_pkg::test_status_e       test_status,
  output ddr_test_pkg::app_addr_t          fail_addr,
  output logic [APP_DATA_W-1:0]            fail_right_data,
  output logic [APP_DATA_W-1:0]            fail_fact_data,
  output logic [ddr_test_pkg::LANES-1:0]   err_lane_mask,
  output ddr_test_pkg::run_cnt_t           test_time,
  output ddr_test_pkg::run_cnt_t           test_finish_cnt
);

  ddr_test_pkg::test_state_e state;
  ddr_test_pkg::run_cfg_t    run;
  ddr_test_pkg::app_addr_t   rd_addr;   // next read address
  logic                      wr_done;
  logic                      rd_done;
  logic                      fail;

  ddr_test_seq #(.PASSES_FULL(PASSES_FULL)) u_seq (.*);

  ddr_app_issue #(
    .APP_DATA_W     (APP_DATA_W),
    .BURSTS_PER_PASS(BURSTS_PER_PASS)
  ) u_issue (.*);

  ddr_rd_check #(
    .APP_DATA_W     (APP_DATA_W),
    .BURSTS_PER_PASS(BURSTS_PER_PASS)
  ) u_check (.*);

endmodule

// ==== verif/app_mem_model.sv ====
module app_mem_model #(
  parameter int APP_DATA_W = 128,
  parameter int RD_LAT     = 4
) (
  input  logic                    W_uclk,
  input  logic                    W_urst,
  input  logic                    app_en,
  input  ddr_test_pkg::cmd_e      app_cmd,
  input  ddr_test_pkg::app_addr_t app_addr,
  input  logic                    app_wdf_wren,
  input  logic [APP_DATA_W-1:0]   app_wdf_data,
  input  ddr_test_pkg::app_addr_t fault_addr,
  input  logic [1:0]              fault_lane,
  output logic                    app_rdy,
  output logic                    app_wdf_rdy,
  output logic                    app_rd_vld,
  output logic [APP_DATA_W-1:0]   app_rd_data
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LANE_W = APP_DATA_W / ddr_test_pkg::LANES;

  logic [APP_DATA_W-1:0] mem [ddr_test_pkg::app_addr_t];
  logic [APP_DATA_W-1:0] rd_q [$];
  int                    due_q [$];  // cycle at which each read returns
  int                    cyc = 0;

  initial
  begin
    app_rdy     = 1'b0;
    app_wdf_rdy = 1'b0;
    app_rd_vld  = 1'b0;
    app_rd_data = '0;
  end

  always @(posedge W_uclk)
  begin : accept
    logic [APP_DATA_W-1:0] d;
    cyc++;
    if (app_wdf_wren)
      mem[app_addr] = app_wdf_data;
    if (app_en && app_rdy && app_cmd == ddr_test_pkg::cmd_rd)
    begin
      d = mem.exists(app_addr) ? mem[app_addr]
                               : APP_DATA_W'({(APP_DATA_W / 32 + 1){3'b101, app_addr}});
      if (app_addr == fault_addr)
        d[fault_lane*LANE_W +: LANE_W] = ~d[fault_lane*LANE_W +: LANE_W];  // stuck lane
      rd_q.push_back(d);
      due_q.push_back(cyc + RD_LAT);
    end
  end

  always @(negedge W_uclk)
  begin
    if (W_urst)
    begin
      app_rdy     = 1'b0;
      app_wdf_rdy = 1'b0;
      app_rd_vld  = 1'b0;
      rd_q.delete();
      due_q.delete();
    end
    else
    begin
      app_rdy     = ($urandom % 4) != 0;  // stall about a quarter of cycles
      app_wdf_rdy = ($urandom % 4) != 0;
      app_rd_vld  = 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cyc)
      begin
        app_rd_vld  = 1'b1;
        app_rd_data = rd_q.pop_front();
        void'(due_q.pop_front());
      end
    end
  end

endmodule

// ==== verif/ddr_selftest_props.sv ====
module ddr_selftest_props (
  input logic                      W_uclk,
  input logic                      W_urst,
  input logic                      app_en,
  input logic                      app_rdy,
  input logic                      app_wdf_wren,
  input ddr_test_pkg::app_addr_t   app_addr,
  input ddr_test_pkg::test_state_e state
);
  timeunit 1ns;
  timeprecision 1ps;

  wren_with_en: assert property (@(posedge W_uclk) disable iff (W_urst)
    app_wdf_wren |-> app_en)
    else $error("app_wdf_wren high without app_en");

  // a write pass always closes through write_end
  write_then_end: assert property (@(posedge W_uclk) disable iff (W_urst)
    state == ddr_test_pkg::st_write |=>
      (state == ddr_test_pkg::st_write || state == ddr_test_pkg::st_write_end))
    else $error("state left write without write_end");

  addr_hold: assert property (@(posedge W_uclk) disable iff (W_urst)
    app_en && !app_rdy |=> $stable(app_addr))
    else $error("app_addr moved while the controller was stalled");

endmodule

bind ddr_selftest ddr_selftest_props props_i (
  .W_uclk      (W_uclk),
  .W_urst      (W_urst),
  .app_en      (app_en),
  .app_rdy     (app_rdy),
  .app_wdf_wren(app_wdf_wren),
  .app_addr    (app_addr),
  .state       (state)
);

// ==== verif/ddr_selftest_tb.sv ====
module ddr_selftest_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int APP_DATA_W      = 128;
  localparam int BURSTS_PER_PASS = 8;
  localparam int PASSES_FULL     = 3;
  localparam int REPS            = APP_DATA_W / 16;
  localparam int LANE_W          = APP_DATA_W / ddr_test_pkg::LANES;
  localparam int COLS            = 8;   // words per pattern line
  localparam int MAX_TESTS       = 16;

  logic                           W_uclk = 1'b0;
  logic                           W_urst;
  logic                           test_en;
  ddr_test_pkg::test_cfg_t        test_cfg;
  logic                           init_done;
  logic                           app_en;
  ddr_test_pkg::cmd_e             app_cmd;
  ddr_test_pkg::app_addr_t        app_addr;
  logic                           app_wdf_wren;
  logic                           app_wdf_end;
  logic [APP_DATA_W-1:0]          app_wdf_data;
  logic                           app_rdy;
  logic                           app_wdf_rdy;
  logic                           app_rd_vld;
  logic [APP_DATA_W-1:0]          app_rd_data;
  ddr_test_pkg::test_status_e     test_status;
  ddr_test_pkg::app_addr_t        fail_addr;
  logic [APP_DATA_W-1:0]          fail_right_data;
  logic [APP_DATA_W-1:0]          fail_fact_data;
  logic [ddr_test_pkg::LANES-1:0] err_lane_mask;
  ddr_test_pkg::run_cnt_t         test_time;
  ddr_test_pkg::run_cnt_t         test_finish_cnt;
  ddr_test_pkg::app_addr_t        fault_addr;
  logic [1:0]                     fault_lane;

  logic [31:0]             pat [0:COLS*MAX_TESTS-1];
  int                      err_count = 0;
  int                      wr_idx = 0;     // bursts written in the current run
  int                      test_cnt = 0;
  int                      bad_tests = 0;
  bit                      timed_out = 1'b0;
  ddr_test_pkg::app_addr_t exp_base = '0;
  logic                    exp_incr = 1'b1;
  ddr_test_pkg::pat_word_t exp_fixed = '0;

  always #10 W_uclk = ~W_uclk;

  ddr_selftest #(
    .APP_DATA_W     (APP_DATA_W),
    .BURSTS_PER_PASS(BURSTS_PER_PASS),
    .PASSES_FULL    (PASSES_FULL)
  ) dut_i (.*);

  app_mem_model #(.APP_DATA_W(APP_DATA_W)) mem_i (.*);

  task automatic check_value(input string name, input logic [APP_DATA_W-1:0] got,
                             input logic [APP_DATA_W-1:0] exp);
    if (got !== exp)
    begin
      err_count++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // polls on falling edges until the status is (or leaves) testing
  task automatic wait_status(input bit want_testing, input int limit, output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < limit)
    begin
      @(negedge W_uclk);
      ok = ((test_status == ddr_test_pkg::testing) == want_testing);
      n++;
    end
  endtask

  // burst k goes to base + 8k with word k or the fixed word
  always @(posedge W_uclk)
  begin : scoreboard
    ddr_test_pkg::pat_word_t word;
    logic                    wr_acc;
    word   = exp_incr ? ddr_test_pkg::pat_word_t'(wr_idx) : exp_fixed;
    wr_acc = app_en && app_rdy && app_wdf_rdy && (app_cmd == ddr_test_pkg::cmd_wr);
    if (!W_urst)
    begin
      check_value("app_wdf_wren", app_wdf_wren, wr_acc);  // write accept rule
      check_value("app_wdf_end", app_wdf_end, wr_acc);    // one beat per burst
    end
    if (!W_urst && app_wdf_wren)
    begin
      check_value("app_addr", app_addr, exp_base + ddr_test_pkg::app_addr_t'(8 * wr_idx));
      check_value("app_wdf_data", app_wdf_data, {REPS{word}});
      wr_idx++;
    end
  end

  initial
  begin
    int                      t;
    int                      b;
    int                      errs_before;
    bit                      ok;
    ddr_test_pkg::pat_word_t k_word;
    logic [APP_DATA_W-1:0]   right;
    logic [APP_DATA_W-1:0]   flip;
    void'($urandom(47317));
    W_urst     = 1'b1;
    test_en    = 1'b0;
    test_cfg   = '0;
    init_done  = 1'b0;
    fault_addr = '1;
    fault_lane = '0;
    for (int i = 0; i < COLS * MAX_TESTS; i++)
      pat[i] = 32'hbad0_0000 | i;  // rows past the table hold no valid mode
    $readmemh("verif/ddr_test_patterns.txt", pat);
    repeat (4) @(negedge W_uclk);
    W_urst    = 1'b0;
    init_done = 1'b1;
    repeat (10)
    begin
      @(negedge W_uclk);
      check_value("app_en", app_en, 1'b0);
      check_value("app_wdf_wren", app_wdf_wren, 1'b0);
      check_value("test_status", test_status, ddr_test_pkg::not_started);
    end
    for (t = 0; t < MAX_TESTS && !timed_out && pat[t*COLS] <= 3; t++)
    begin
      b           = t * COLS;
      errs_before = err_count;
      @(negedge W_uclk);
      test_cfg.mode       = ddr_test_pkg::test_mode_e'(pat[b][1:0]);
      test_cfg.fixed_data = pat[b+1][15:0];
      test_cfg.start_addr = pat[b+2][28:0];
      test_cfg.end_addr   = pat[b+3][28:0];
      fault_addr          = pat[b+4][28:0];
      fault_lane          = pat[b+5][1:0];
      exp_incr            = !pat[b][0];  // modes 0 and 2 increment
      exp_fixed           = pat[b+1][15:0];
      exp_base            = pat[b][1] ? pat[b+2][28:0] : '0;
      wr_idx              = 0;
      @(negedge W_uclk);
      test_en = 1'b1;  // fresh rising edge
      wait_status(1'b1, 20, ok);
      if (ok)
        wait_status(1'b0, 20000, ok);
      if (!ok)
      begin
        timed_out = 1'b1;
        $display("test %0d: test_status did not change in time", t);
      end
      else
      begin
        check_value("test_finish_cnt", test_finish_cnt, 1);
        check_value("test_status", test_status, pat[b+6][1:0]);
        check_value("write_count", wr_idx, pat[b+7]);
        check_value("test_time_nonzero", test_time != 0, 1'b1);
        if (test_status == ddr_test_pkg::failed)
        begin
          k_word = exp_incr ? ddr_test_pkg::pat_word_t'((fault_addr - exp_base) / 8)
                            : exp_fixed;
          right  = {REPS{k_word}};
          flip   = '0;
          flip[fault_lane*LANE_W +: LANE_W] = '1;
          check_value("fail_addr", fail_addr, fault_addr);
          check_value("fail_right_data", fail_right_data, right);
          check_value("fail_fact_data", fail_fact_data, right ^ flip);
          check_value("err_lane_mask", err_lane_mask, 1 << fault_lane);
          repeat (20)  // enable held high, no restart
          begin
            @(negedge W_uclk);
            check_value("test_status", test_status, ddr_test_pkg::failed);
            check_value("app_en", app_en, 1'b0);
          end
        end
      end
      test_en = 1'b0;
      test_cnt++;
      if (err_count != errs_before || timed_out)
        bad_tests++;
      $display("test %0d mode %0d: %0d mismatches", t, pat[b][1:0], err_count - errs_before);
    end
    $display("tests %0d, failing tests %0d, mismatches %0d", test_cnt, bad_tests, err_count);
    if (err_count == 0 && !timed_out && test_cnt > 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== verif/ddr_test_patterns.txt ====
// mode fixed_word start_addr end_addr fault_addr(1fffffff none) fault_lane exp_status exp_bursts
// all hex, one test per line; status 2 passed, 3 failed
0 0000 00000000 00000000 1fffffff 0 2 18
1 5a3c 00000000 00000000 1fffffff 0 2 18
3 beef 00000040 00000100 1fffffff 0 2 18
3 0f0f 00000080 000000c8 1fffffff 0 2 10
2 0000 00000300 00000380 1fffffff 0 2 10
2 0000 00000200 00000400 00000218 2 3 08
1 c3a5 00000000 00000000 1fffffff 0 2 18

// ==== filelist.f ====
logic/ddr_test_pkg.sv
logic/ddr_test_seq.sv
logic/ddr_app_issue.sv
logic/ddr_rd_check.sv
logic/ddr_selftest.sv
verif/app_mem_model.sv
verif/ddr_selftest_props.sv
verif/ddr_selftest_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ddr_selftest_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
